/* sim.f */
+incdir+include
logic/la_isa_pkg.sv
logic/la_core_pkg.sv
logic/la_stage_ifs.sv
logic/la_fetch_ctrl.sv
logic/la_decode.sv
logic/la_regfile.sv
logic/la_execute.sv
logic/la_mem_wb.sv
logic/la_core_top.sv
dv/tb_checker.sv
dv/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 -Wno-fatal
TOP       := tb_top
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation reported failure" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tb_top.sv */
`default_nettype none
`include "la_core_settings.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_random = 200;

    logic                clk;
    logic                reset;
    logic [`LA_XLEN-1:0] inst_sram_addr;
    logic [`LA_XLEN-1:0] inst_sram_rdata;
    logic                data_sram_we;
    logic [`LA_XLEN-1:0] data_sram_addr;
    logic [`LA_XLEN-1:0] data_sram_wdata;
    logic [`LA_XLEN-1:0] data_sram_rdata;
    logic [`LA_XLEN-1:0] debug_wb_pc;
    logic [3:0]          debug_wb_rf_we;
    logic [4:0]          debug_wb_rf_wnum;
    logic [`LA_XLEN-1:0] debug_wb_rf_wdata;
    logic [`LA_XLEN-1:0] inst_offs;
    logic [31:0]         imem [1024];
    logic [31:0]         dmem [1024];
    logic [31:0]         spin_addr;
    int                  prog_len;
    int                  total_errors;
    bit                  prog_built;
    integer              seed;

    la_core_top UUT (.*);

    tb_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // both SRAMs register the address and answer next cycle.
    assign inst_offs = inst_sram_addr - `LA_RESET_PC;

    always @(posedge clk) begin
        inst_sram_rdata <= imem[inst_offs[11:2]];
        if (data_sram_we) begin
            dmem[data_sram_addr[11:2]] <= data_sram_wdata;
        end
        data_sram_rdata <= dmem[data_sram_addr[11:2]];
    end

    function automatic logic [31:0] r3(input logic [16:0] op, input int rd, rj, rk);
        return {op, 5'(rk), 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] ri12(input logic [9:0] op, input int rd, rj, imm);
        return {op, 12'(imm), 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] br16(input logic [5:0] op, input int rj, rd, words);
        return {op, 16'(words), 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] br26(input logic [5:0] op, input int words);
        logic [25:0] o;
        o = 26'(words);
        return {op, o[15:0], o[25:16]};
    endfunction

    function automatic logic [31:0] lu12i(input int rd, input logic [19:0] imm);
        return {7'h0a, imm, 5'(rd)};
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic add_random();
        logic [31:0] r;
        int          rd;
        int          rj;
        int          rk;
        logic [16:0] minor [8];
        minor = '{17'h20, 17'h22, 17'h24, 17'h25, 17'h28, 17'h29, 17'h2a, 17'h2b};
        r  = $random(seed);
        rd = int'($unsigned($random(seed)) % 15) + 1;
        rj = int'($unsigned($random(seed)) % 15) + 1;
        rk = int'($unsigned($random(seed)) % 15) + 1;
        case (r % 13)
            0, 1, 2, 3, 4, 5, 6, 7: emit(r3(minor[r % 13], rd, rj, rk));
            8:  emit(r3(17'h81, rd, rj, int'(r[12:8])));
            9:  emit(r3(17'h89, rd, rj, int'(r[12:8])));
            10: emit(r3(17'h91, rd, rj, int'(r[12:8])));
            11: emit(ri12(10'h00a, rd, rj, int'(r[31:20])));
            default: emit(lu12i(rd, r[31:12]));
        endcase
    endtask

    task automatic build_program();
        int n;
        prog_len = 0;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = '0;
            dmem[i] <= (32'(i * 4) * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
        end
        // arithmetic and logic with mixed signs.
        emit(ri12(10'h00a, 1, 0, -5));
        emit(lu12i(2, 20'h80000));
        emit(ri12(10'h00a, 2, 2, 7));
        emit(ri12(10'h00a, 3, 0, 100));
        emit(r3(17'h20, 4, 1, 3));
        emit(r3(17'h22, 5, 1, 3));
        emit(r3(17'h24, 6, 1, 3));
        emit(r3(17'h25, 7, 1, 3));
        emit(r3(17'h24, 8, 2, 1));
        emit(r3(17'h25, 9, 2, 1));
        emit(r3(17'h28, 10, 1, 3));
        emit(r3(17'h29, 11, 2, 1));
        emit(r3(17'h2a, 12, 1, 3));
        emit(r3(17'h2b, 13, 2, 3));
        // shifts and immediates.
        emit(r3(17'h81, 14, 1, 3));
        emit(r3(17'h89, 15, 2, 4));
        emit(r3(17'h91, 16, 2, 4));
        emit(r3(17'h91, 17, 1, 1));
        emit(ri12(10'h00a, 18, 3, -2048));
        emit(lu12i(19, 20'habcde));
        // stores then loads from the same and an untouched word.
        emit(ri12(10'h00a, 20, 0, 32'h100));
        emit(ri12(10'h0a6, 4, 20, 0));
        emit(ri12(10'h0a6, 13, 20, 8));
        emit(ri12(10'h0a2, 21, 20, 0));
        emit(ri12(10'h0a2, 22, 20, 8));
        emit(ri12(10'h0a2, 23, 20, 4));
        emit(ri12(10'h0a6, 1, 20, -4));
        emit(ri12(10'h0a2, 24, 20, -4));
        // conditional branches both ways and then b.
        emit(br16(6'h16, 3, 3, 2));
        emit(ri12(10'h00a, 25, 0, 1));
        emit(ri12(10'h00a, 25, 0, 2));
        emit(br16(6'h16, 1, 3, 2));
        emit(ri12(10'h00a, 26, 0, 3));
        emit(br16(6'h17, 1, 3, 2));
        emit(ri12(10'h00a, 26, 0, 4));
        emit(br16(6'h17, 3, 3, 2));
        emit(ri12(10'h00a, 27, 0, 5));
        emit(br26(6'h14, 2));
        emit(ri12(10'h00a, 27, 0, 6));
        emit(ri12(10'h00a, 28, 0, 7));
        // bl skips one word and jirl lands at rj plus one word.
        emit(br26(6'h15, 2));
        emit(ri12(10'h00a, 29, 0, 8));
        n = prog_len;
        emit(lu12i(31, 20'h1c000));
        emit(ri12(10'h00a, 31, 31, (n + 3) * 4));
        emit(br16(6'h13, 31, 30, 1));
        emit(ri12(10'h00a, 29, 0, 9));
        emit(r3(17'h20, 29, 30, 0));
        // r0 stays zero.
        emit(ri12(10'h00a, 0, 0, 123));
        emit(r3(17'h20, 0, 1, 3));
        emit(r3(17'h20, 5, 0, 0));
        emit(ri12(10'h00a, 6, 0, 9));
        for (int i = 0; i < num_random; i++) begin
            add_random();
        end
        spin_addr = `LA_RESET_PC + 32'(prog_len * 4);
        emit(br26(6'h14, 0));
    endtask

    initial begin
        reset           <= 1'b1;
        inst_sram_rdata <= '0;
        data_sram_rdata <= '0;
        seed            = 32'h2600;
        build_program();
        prog_built = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        while (inst_sram_addr != spin_addr) begin
            @(posedge clk);
        end
        // let the last instruction retire.
        repeat (8) @(posedge clk);
        if (u_checker.model_pc != spin_addr) begin
            $display("reference stopped at %h instead of the final branch", u_checker.model_pc);
            u_checker.other_errors++;
        end
        u_checker.check_stores_drained();
        total_errors = u_checker.value_errors + u_checker.other_errors;
        $display("checks done: %0d retired, %0d value errors, %0d other errors",
                 u_checker.retired, u_checker.value_errors, u_checker.other_errors);
        if (total_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (prog_built);
        repeat (prog_len * 5 + 200) @(posedge clk);
        $display("timeout: the core did not reach the final branch in time");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/tb_checker.sv */
`default_nettype none
`include "la_core_settings.svh"

module tb_checker (
    input wire                clk,
    input wire                reset,
    input wire                data_sram_we,
    input wire [`LA_XLEN-1:0] data_sram_addr,
    input wire [`LA_XLEN-1:0] data_sram_wdata,
    input wire [`LA_XLEN-1:0] debug_wb_pc,
    input wire [3:0]          debug_wb_rf_we,
    input wire [4:0]          debug_wb_rf_wnum,
    input wire [`LA_XLEN-1:0] debug_wb_rf_wdata
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_skip = 64;

    logic [31:0] model_regs [32];
    logic [31:0] model_dmem [1024];
    logic [31:0] model_pc;
    logic [31:0] store_addr_q [$];
    logic [31:0] store_data_q [$];
    int          value_errors;
    int          other_errors;
    int          retired;
    bit          mem_loaded;

    // expected result of the last instruction the model ran.
    logic        exp_we;
    logic [4:0]  exp_wnum;
    logic [31:0] exp_wdata;
    logic [31:0] exp_pc;
    string       exp_name;

    initial begin
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_pc     = `LA_RESET_PC;
        value_errors = 0;
        other_errors = 0;
        retired      = 0;
        mem_loaded   = 1'b0;
    end

    function automatic void check_store(input logic [31:0] addr, input logic [31:0] data);
        if (store_addr_q.size() == 0) begin
            $display("store at %h never appeared on the data SRAM port", addr);
            other_errors++;
        end else begin
            if (store_addr_q[0] !== addr) begin
                $display("FAILED st.w addr: expected %h, actual %h", addr, store_addr_q[0]);
                value_errors++;
            end
            if (store_data_q[0] !== data) begin
                $display("FAILED st.w data: expected %h, actual %h", data, store_data_q[0]);
                value_errors++;
            end
            void'(store_addr_q.pop_front());
            void'(store_data_q.pop_front());
        end
    endfunction

    // every data SRAM write has to meet a st.w in the reference.
    function automatic void check_stores_drained();
        if (store_addr_q.size() != 0) begin
            $display("%0d data SRAM writes had no matching store in the reference",
                     store_addr_q.size());
            other_errors++;
        end
    endfunction

    // reference model for one instruction.
    function automatic void exec_one();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] next_pc;
        logic [31:0] si12;
        logic [31:0] offs16;
        logic [31:0] offs26;
        logic [4:0]  rd;
        logic        wr;
        w       = tb_top.imem[model_pc[11:2]];
        rd      = w[4:0];
        a       = model_regs[w[9:5]];
        b       = model_regs[w[14:10]];
        si12    = {{20{w[21]}}, w[21:10]};
        offs16  = {{14{w[25]}}, w[25:10], 2'b00};
        offs26  = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
        addr    = a + si12;
        next_pc = model_pc + 32'd4;
        res     = '0;
        wr      = 1'b1;
        exp_pc  = model_pc;
        if (w[31:15] == 17'h00020) begin
            exp_name = "add.w";
            res = a + b;
        end else if (w[31:15] == 17'h00022) begin
            exp_name = "sub.w";
            res = a - b;
        end else if (w[31:15] == 17'h00024) begin
            exp_name = "slt";
            res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        end else if (w[31:15] == 17'h00025) begin
            exp_name = "sltu";
            res = (a < b) ? 32'd1 : 32'd0;
        end else if (w[31:15] == 17'h00028) begin
            exp_name = "nor";
            res = ~(a | b);
        end else if (w[31:15] == 17'h00029) begin
            exp_name = "and";
            res = a & b;
        end else if (w[31:15] == 17'h0002a) begin
            exp_name = "or";
            res = a | b;
        end else if (w[31:15] == 17'h0002b) begin
            exp_name = "xor";
            res = a ^ b;
        end else if (w[31:15] == 17'h00081) begin
            exp_name = "slli.w";
            res = a << w[14:10];
        end else if (w[31:15] == 17'h00089) begin
            exp_name = "srli.w";
            res = a >> w[14:10];
        end else if (w[31:15] == 17'h00091) begin
            exp_name = "srai.w";
            res = 32'($signed(a) >>> w[14:10]);
        end else if (w[31:22] == 10'h00a) begin
            exp_name = "addi.w";
            res = addr;
        end else if (w[31:22] == 10'h0a2) begin
            exp_name = "ld.w";
            res = model_dmem[addr[11:2]];
        end else if (w[31:22] == 10'h0a6) begin
            exp_name = "st.w";
            wr = 1'b0;
            check_store(addr, model_regs[rd]);
            model_dmem[addr[11:2]] = model_regs[rd];
        end else if (w[31:25] == 7'h0a) begin
            exp_name = "lu12i.w";
            res = {w[24:5], 12'h000};
        end else if (w[31:26] == 6'h13) begin
            exp_name = "jirl";
            res = model_pc + 32'd4;
            next_pc = a + offs16;
        end else if (w[31:26] == 6'h14) begin
            exp_name = "b";
            wr = 1'b0;
            next_pc = model_pc + offs26;
        end else if (w[31:26] == 6'h15) begin
            exp_name = "bl";
            rd = 5'd1;
            res = model_pc + 32'd4;
            next_pc = model_pc + offs26;
        end else if (w[31:26] == 6'h16 || w[31:26] == 6'h17) begin
            exp_name = (w[26]) ? "bne" : "beq";
            wr = 1'b0;
            if ((a == model_regs[rd]) != w[26]) begin
                next_pc = model_pc + offs16;
            end
        end else begin
            exp_name = "invalid";
            wr = 1'b0;
        end
        exp_we    = wr && (rd != 5'd0);
        exp_wnum  = rd;
        exp_wdata = res;
        if (exp_we) begin
            model_regs[rd] = res;
        end
        model_pc = next_pc;
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED %s %s at pc %h: expected %h, actual %h",
                     exp_name, what, exp_pc, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_retire();
        int steps;
        steps  = 0;
        exp_we = 1'b0;
        // branches, stores and r0 writes leave no trace.
        while (!exp_we && steps < max_skip) begin
            exec_one();
            steps++;
        end
        if (!exp_we) begin
            $display("reference ran %0d instructions without a register write", max_skip);
            other_errors++;
        end else begin
            retired++;
            compare("pc", exp_pc, debug_wb_pc);
            compare("wnum", 32'(exp_wnum), 32'(debug_wb_rf_wnum));
            compare("wdata", exp_wdata, debug_wb_rf_wdata);
            compare("rf_we", 32'hf, 32'(debug_wb_rf_we));
        end
    endtask

    task automatic load_memory();
        for (int i = 0; i < 1024; i++) begin
            model_dmem[i] = tb_top.dmem[i];
        end
        mem_loaded = 1'b1;
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (!mem_loaded) begin
                load_memory();
            end
            if (data_sram_we) begin
                store_addr_q.push_back(data_sram_addr);
                store_data_q.push_back(data_sram_wdata);
            end
            if (debug_wb_rf_we != 4'h0) begin
                check_retire();
            end
        end
    end

endmodule

`default_nettype wire

/* logic/la_core_top.sv */
`default_nettype none
`include "la_core_settings.svh"

module la_core_top (
    input  wire                                 clk,
    input  wire                                 reset,
    output logic [`LA_XLEN-1:0]                 inst_sram_addr,
    input  wire  [`LA_XLEN-1:0]                 inst_sram_rdata,
    output logic                                data_sram_we,
    output logic [`LA_XLEN-1:0]                 data_sram_addr,
    output logic [`LA_XLEN-1:0]                 data_sram_wdata,
    input  wire  [`LA_XLEN-1:0]                 data_sram_rdata,
    output logic [`LA_XLEN-1:0]                 debug_wb_pc,
    output logic [3:0]                          debug_wb_rf_we,
    output logic [la_isa_pkg::reg_idx_w-1:0]    debug_wb_rf_wnum,
    output logic [`LA_XLEN-1:0]                 debug_wb_rf_wdata
);
    import la_isa_pkg::*;
    import la_core_pkg::*;

    core_state_e         state;
    la_class_e           inst_class;
    logic [`LA_XLEN-1:0] pc;
    logic                br_taken;
    logic [`LA_XLEN-1:0] br_target;
    la_reg_idx_t         rf_raddr1;
    la_reg_idx_t         rf_raddr2;
    logic [`LA_XLEN-1:0] rf_rdata1;
    logic [`LA_XLEN-1:0] rf_rdata2;
    logic                rf_we;
    la_reg_idx_t         rf_waddr;
    logic [`LA_XLEN-1:0] rf_wdata;

    dec_exe_if dx ();
    exe_wb_if  xw ();

    la_fetch_ctrl u_fetch_ctrl (
        .clk, .reset, .inst_class, .br_taken, .br_target, .state, .pc, .inst_sram_addr
    );

    la_decode u_decode (
        .clk, .reset, .state, .pc, .inst_sram_rdata,
        .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
        .inst_class, .br_taken, .br_target, .dx(dx.decode)
    );

    la_regfile u_regfile (
        .clk,
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    la_execute u_execute (
        .clk, .reset, .state, .dx(dx.execute), .xw(xw.execute)
    );

    la_mem_wb u_mem_wb (
        .clk, .reset, .state, .pc, .xw(xw.mem_wb),
        .data_sram_we, .data_sram_addr, .data_sram_wdata, .data_sram_rdata,
        .rf_we, .rf_waddr, .rf_wdata,
        .debug_wb_pc, .debug_wb_rf_we, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

endmodule

`default_nettype wire

/* logic/la_mem_wb.sv */
`default_nettype none
`include "la_core_settings.svh"

module la_mem_wb (
    input  wire                           clk,
    input  wire                           reset,
    input  wire la_core_pkg::core_state_e state,
    input  wire [`LA_XLEN-1:0]            pc,
    exe_wb_if.mem_wb                      xw,
    output logic                          data_sram_we,
    output logic [`LA_XLEN-1:0]           data_sram_addr,
    output logic [`LA_XLEN-1:0]           data_sram_wdata,
    input  wire [`LA_XLEN-1:0]            data_sram_rdata,
    output logic                          rf_we,
    output la_isa_pkg::la_reg_idx_t       rf_waddr,
    output logic [`LA_XLEN-1:0]           rf_wdata,
    output logic [`LA_XLEN-1:0]           debug_wb_pc,
    output logic [3:0]                    debug_wb_rf_we,
    output la_isa_pkg::la_reg_idx_t       debug_wb_rf_wnum,
    output logic [`LA_XLEN-1:0]           debug_wb_rf_wdata
);
    import la_core_pkg::*;

    logic in_mem;
    logic rdata_valid;

    assign in_mem = (state == st_memory);

    // the sram port is idle outside st_memory.
    assign data_sram_we    = in_mem && xw.mem_we;
    assign data_sram_addr  = in_mem ? xw.alu_result : '0;
    assign data_sram_wdata = in_mem ? xw.store_data : '0;

    // load word arrives one cycle after its address.
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= in_mem && xw.res_from_mem;
        end
    end

    assign rf_we    = (state == st_writeback) && xw.gr_we && (xw.dest != '0);
    assign rf_waddr = xw.dest;
    assign rf_wdata = rdata_valid ? data_sram_rdata : xw.alu_result;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = xw.dest;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

`default_nettype wire

/* logic/la_execute.sv */
`default_nettype none
`include "la_core_settings.svh"

module la_execute (
    input  wire                           clk,
    input  wire                           reset,
    input  wire la_core_pkg::core_state_e state,
    dec_exe_if.execute                    dx,
    exe_wb_if.execute                     xw
);
    import la_core_pkg::*;

    logic [4:0]          shamt;
    logic [`LA_XLEN-1:0] alu_out;

    assign shamt = dx.src2[4:0];

    always_comb begin
        case (dx.alu_op)
            alu_add:  alu_out = dx.src1 + dx.src2;
            alu_sub:  alu_out = dx.src1 - dx.src2;
            alu_slt:  alu_out = {{(`LA_XLEN-1){1'b0}}, $signed(dx.src1) < $signed(dx.src2)};
            alu_sltu: alu_out = {{(`LA_XLEN-1){1'b0}}, dx.src1 < dx.src2};
            alu_and:  alu_out = dx.src1 & dx.src2;
            alu_nor:  alu_out = ~(dx.src1 | dx.src2);
            alu_or:   alu_out = dx.src1 | dx.src2;
            alu_xor:  alu_out = dx.src1 ^ dx.src2;
            alu_sll:  alu_out = dx.src1 << shamt;
            alu_srl:  alu_out = dx.src1 >> shamt;
            alu_sra:  alu_out = $unsigned($signed(dx.src1) >>> shamt);
            // upper immediate is already built by decode.
            alu_lui:  alu_out = dx.src2;
            default:  alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            xw.gr_we        <= 1'b0;
            xw.mem_we       <= 1'b0;
            xw.res_from_mem <= 1'b0;
        end else if (state == st_execute) begin
            xw.gr_we        <= dx.gr_we;
            xw.mem_we       <= dx.mem_we;
            xw.res_from_mem <= dx.res_from_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_execute) begin
            xw.alu_result <= alu_out;
            xw.store_data <= dx.store_data;
            xw.dest       <= dx.dest;
        end
    end

endmodule

`default_nettype wire

/* logic/la_regfile.sv */
`default_nettype none
`include "la_core_settings.svh"

module la_regfile (
    input  wire                          clk,
    input  wire la_isa_pkg::la_reg_idx_t raddr1,
    input  wire la_isa_pkg::la_reg_idx_t raddr2,
    output logic [`LA_XLEN-1:0]          rdata1,
    output logic [`LA_XLEN-1:0]          rdata2,
    input  wire                          we,
    input  wire la_isa_pkg::la_reg_idx_t waddr,
    input  wire [`LA_XLEN-1:0]           wdata
);
    logic [`LA_XLEN-1:0] regs [`LA_NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is never written, so force its read.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* logic/la_decode.sv */
`default_nettype none
`include "la_core_settings.svh"

module la_decode (
    input  wire                           clk,
    input  wire                           reset,
    input  wire la_core_pkg::core_state_e state,
    input  wire [`LA_XLEN-1:0]            pc,
    input  wire [`LA_XLEN-1:0]            inst_sram_rdata,
    output la_isa_pkg::la_reg_idx_t       rf_raddr1,
    output la_isa_pkg::la_reg_idx_t       rf_raddr2,
    input  wire [`LA_XLEN-1:0]            rf_rdata1,
    input  wire [`LA_XLEN-1:0]            rf_rdata2,
    output la_isa_pkg::la_class_e         inst_class,
    output logic                          br_taken,
    output logic [`LA_XLEN-1:0]           br_target,
    dec_exe_if.decode                     dx
);
    import la_isa_pkg::*;
    import la_core_pkg::*;

    la_opcode_e          opcode;
    alu_op_e             alu_op;
    la_reg_idx_t         rd;
    la_reg_idx_t         rj;
    la_reg_idx_t         rk;
    logic [si12_w-1:0]   i12;
    logic [si16_w-1:0]   i16;
    logic [si20_w-1:0]   i20;
    logic [si26_w-1:0]   i26;
    logic [`LA_XLEN-1:0] imm;
    logic [`LA_XLEN-1:0] offs16;
    logic [`LA_XLEN-1:0] offs26;
    logic                use_imm;
    logic                gr_we;

    assign rd  = inst_sram_rdata[4:0];
    assign rj  = inst_sram_rdata[9:5];
    assign rk  = inst_sram_rdata[14:10];
    assign i12 = inst_sram_rdata[21:10];
    assign i16 = inst_sram_rdata[25:10];
    assign i20 = inst_sram_rdata[24:5];
    assign i26 = {inst_sram_rdata[9:0], inst_sram_rdata[25:10]};

    // major opcode, then minor fields down to bit 15.
    always_comb begin
        casez (inst_sram_rdata[31:15])
            17'b000000_0000_01_00000: opcode = op_add_w;
            17'b000000_0000_01_00010: opcode = op_sub_w;
            17'b000000_0000_01_00100: opcode = op_slt;
            17'b000000_0000_01_00101: opcode = op_sltu;
            17'b000000_0000_01_01000: opcode = op_nor;
            17'b000000_0000_01_01001: opcode = op_and;
            17'b000000_0000_01_01010: opcode = op_or;
            17'b000000_0000_01_01011: opcode = op_xor;
            17'b000000_0001_00_00001: opcode = op_slli_w;
            17'b000000_0001_00_01001: opcode = op_srli_w;
            17'b000000_0001_00_10001: opcode = op_srai_w;
            17'b000000_1010_??_?????: opcode = op_addi_w;
            17'b001010_0010_??_?????: opcode = op_ld_w;
            17'b001010_0110_??_?????: opcode = op_st_w;
            17'b010011_????_??_?????: opcode = op_jirl;
            17'b010100_????_??_?????: opcode = op_b;
            17'b010101_????_??_?????: opcode = op_bl;
            17'b010110_????_??_?????: opcode = op_beq;
            17'b010111_????_??_?????: opcode = op_bne;
            17'b000101_0???_??_?????: opcode = op_lu12i_w;
            default:                  opcode = op_invalid;
        endcase
    end

    always_comb begin
        case (opcode)
            op_sub_w:   alu_op = alu_sub;
            op_slt:     alu_op = alu_slt;
            op_sltu:    alu_op = alu_sltu;
            op_nor:     alu_op = alu_nor;
            op_and:     alu_op = alu_and;
            op_or:      alu_op = alu_or;
            op_xor:     alu_op = alu_xor;
            op_slli_w:  alu_op = alu_sll;
            op_srli_w:  alu_op = alu_srl;
            op_srai_w:  alu_op = alu_sra;
            op_lu12i_w: alu_op = alu_lui;
            default:    alu_op = alu_add;
        endcase
    end

    // link instructions add 4 to the pc.
    always_comb begin
        case (opcode)
            op_slli_w, op_srli_w, op_srai_w: imm = {{(`LA_XLEN-reg_idx_w){1'b0}}, rk};
            op_lu12i_w:                      imm = {i20, {(`LA_XLEN-si20_w){1'b0}}};
            op_jirl, op_bl:                  imm = `LA_XLEN'(4);
            default:                         imm = {{(`LA_XLEN-si12_w){i12[si12_w-1]}}, i12};
        endcase
    end

    always_comb begin
        case (opcode)
            op_ld_w:            inst_class = cls_load;
            op_st_w:            inst_class = cls_store;
            op_b, op_beq, op_bne: inst_class = cls_branch;
            default:            inst_class = cls_alu;
        endcase
    end

    assign use_imm = !(opcode inside {op_add_w, op_sub_w, op_slt, op_sltu,
                                      op_nor, op_and, op_or, op_xor});
    // unknown words fall through as a non-writing alu op.
    assign gr_we   = !(opcode inside {op_st_w, op_b, op_beq, op_bne, op_invalid});

    assign rf_raddr1 = rj;
    assign rf_raddr2 = (opcode inside {op_beq, op_bne, op_st_w}) ? rd : rk;

    assign offs16 = {{(`LA_XLEN-si16_w-2){i16[si16_w-1]}}, i16, 2'b00};
    assign offs26 = {{(`LA_XLEN-si26_w-2){i26[si26_w-1]}}, i26, 2'b00};

    assign br_taken  = (opcode inside {op_b, op_bl, op_jirl})
                     || (opcode == op_beq && rf_rdata1 == rf_rdata2)
                     || (opcode == op_bne && rf_rdata1 != rf_rdata2);
    assign br_target = (opcode == op_jirl) ? rf_rdata1 + offs16 :
                       pc + ((opcode inside {op_b, op_bl}) ? offs26 : offs16);

    always_ff @(posedge clk) begin
        if (reset) begin
            dx.gr_we        <= 1'b0;
            dx.mem_we       <= 1'b0;
            dx.res_from_mem <= 1'b0;
        end else if (state == st_decode) begin
            dx.gr_we        <= gr_we;
            dx.mem_we       <= (opcode == op_st_w);
            dx.res_from_mem <= (opcode == op_ld_w);
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            dx.alu_op     <= alu_op;
            dx.src1       <= (opcode inside {op_jirl, op_bl}) ? pc : rf_rdata1;
            dx.src2       <= use_imm ? imm : rf_rdata2;
            dx.store_data <= rf_rdata2;
            // bl links into r1.
            dx.dest       <= (opcode == op_bl) ? la_reg_idx_t'(1) : rd;
        end
    end

endmodule

`default_nettype wire

/* logic/la_fetch_ctrl.sv */
`default_nettype none
`include "la_core_settings.svh"

module la_fetch_ctrl (
    input  wire                        clk,
    input  wire                        reset,
    input  wire la_isa_pkg::la_class_e inst_class,
    input  wire                        br_taken,
    input  wire [`LA_XLEN-1:0]         br_target,
    output la_core_pkg::core_state_e   state,
    output logic [`LA_XLEN-1:0]        pc,
    output logic [`LA_XLEN-1:0]        inst_sram_addr
);
    import la_isa_pkg::*;
    import la_core_pkg::*;

    core_state_e         state_next;
    la_class_e           class_q;
    logic [`LA_XLEN-1:0] fetch_pc;

    // the word is only on the sram port during st_decode, so keep its class.
    always_comb begin
        case (state)
            st_fetch:   state_next = st_decode;
            st_decode:  state_next = (inst_class == cls_branch) ? st_fetch : st_execute;
            st_execute: begin
                if (class_q == cls_load || class_q == cls_store) begin
                    state_next = st_memory;
                end else begin
                    state_next = st_writeback;
                end
            end
            st_memory:  state_next = (class_q == cls_load) ? st_writeback : st_fetch;
            default:    state_next = st_fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_fetch;
            class_q  <= cls_alu;
            fetch_pc <= `LA_RESET_PC;
            pc       <= `LA_RESET_PC;
        end else begin
            state <= state_next;
            // pc holds the retiring address until the next fetch.
            if (state == st_fetch) begin
                pc <= fetch_pc;
            end
            if (state == st_decode) begin
                class_q  <= inst_class;
                fetch_pc <= br_taken ? br_target : pc + `LA_XLEN'(4);
            end
        end
    end

    assign inst_sram_addr = fetch_pc;

endmodule

`default_nettype wire

/* logic/la_stage_ifs.sv */
`default_nettype none
`include "la_core_settings.svh"

// decode to execute, held from one st_decode to the next.
interface dec_exe_if;
    la_core_pkg::alu_op_e    alu_op;
    logic [`LA_XLEN-1:0]     src1;
    logic [`LA_XLEN-1:0]     src2;
    logic [`LA_XLEN-1:0]     store_data;
    la_isa_pkg::la_reg_idx_t dest;
    logic                    gr_we;
    logic                    mem_we;
    logic                    res_from_mem;

    modport decode (
        output alu_op, src1, src2, store_data, dest, gr_we, mem_we, res_from_mem
    );
    modport execute (
        input alu_op, src1, src2, store_data, dest, gr_we, mem_we, res_from_mem
    );
endinterface

// execute to memory/writeback.
interface exe_wb_if;
    logic [`LA_XLEN-1:0]     alu_result;
    logic [`LA_XLEN-1:0]     store_data;
    la_isa_pkg::la_reg_idx_t dest;
    logic                    gr_we;
    logic                    mem_we;
    logic                    res_from_mem;

    modport execute (
        output alu_result, store_data, dest, gr_we, mem_we, res_from_mem
    );
    modport mem_wb (
        input alu_result, store_data, dest, gr_we, mem_we, res_from_mem
    );
endinterface

`default_nettype wire

/* logic/la_core_pkg.sv */
`default_nettype none

package la_core_pkg;

    // one instruction walks through these in order.
    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback
    } core_state_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

endpackage

`default_nettype wire

/* logic/la_isa_pkg.sv */
`default_nettype none

package la_isa_pkg;

    // instruction field widths.
    localparam int unsigned reg_idx_w = 5;
    localparam int unsigned si12_w    = 12;
    localparam int unsigned si16_w    = 16;
    localparam int unsigned si20_w    = 20;
    localparam int unsigned si26_w    = 26;

    typedef logic [reg_idx_w-1:0] la_reg_idx_t;

    // supported subset of the base integer set.
    typedef enum logic [4:0] {
        op_add_w,
        op_sub_w,
        op_slt,
        op_sltu,
        op_nor,
        op_and,
        op_or,
        op_xor,
        op_slli_w,
        op_srli_w,
        op_srai_w,
        op_addi_w,
        op_ld_w,
        op_st_w,
        op_jirl,
        op_b,
        op_bl,
        op_beq,
        op_bne,
        op_lu12i_w,
        op_invalid
    } la_opcode_e;

    // decides the cycle count of an instruction.
    typedef enum logic [1:0] {
        cls_alu,
        cls_load,
        cls_store,
        cls_branch
    } la_class_e;

endpackage

`default_nettype wire

/* include/la_core_settings.svh */
`ifndef LA_CORE_SETTINGS_SVH
`define LA_CORE_SETTINGS_SVH

// machine word and address width.
`define LA_XLEN 32

// architectural integer registers.
`define LA_NUM_REGS 32

// first fetch address after reset.
`define LA_RESET_PC 32'h1c00_0000

`endif
